// ==== project.f ====
verilog/io_pkg.sv
verilog/uart_if.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/io_regs.sv
verilog/io_top.sv
sim/io_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module io_tb \
    && ./obj_dir/Vio_tb | awk '{ print } /SIMULATION PASSED/ { found = 1 } END { exit !found }' \
    && echo "run.sh: simulation run ok" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

// ==== sim/io_tb.sv ====
`timescale 1ns/1ps

module io_tb import io_pkg::*; ();

    localparam int frame_clks    = 10 * clks_per_bit;
    localparam int watchdog_clks = 20 * frame_clks + 10000;

    logic        clk;
    logic        rst;
    logic [31:0] addr;
    logic [31:0] din;
    logic        io_en;
    logic        inst_ret;
    logic        br_inst;
    logic        br_suc;
    logic        serial_in;
    logic        serial_out;
    logic [31:0] dout;

    logic [31:0] rng;
    logic [7:0]  tx_sent[$];
    logic [7:0]  tx_seen[$]; // bytes decoded from serial_out in arrival order

    io_top io_top_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .din        (din),
        .io_en      (io_en),
        .inst_ret   (inst_ret),
        .br_inst    (br_inst),
        .br_suc     (br_suc),
        .serial_in  (serial_in),
        .serial_out (serial_out),
        .dout       (dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // read data only shows up in the cycle right after a strobe
    assert property (@(posedge clk) disable iff (rst) !$past(io_en) |-> dout == 32'd0)
        else begin
            $display("FAIL time %0t dout expected %h actual %h", $time, 32'd0, $sampled(dout));
            $display("SIMULATION FAILED");
            $fatal(1, "dout not zero after an idle cycle");
        end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    // one strobe whose result is sampled at the falling edge after it
    task automatic read_reg(input logic [31:0] a, output logic [31:0] d);
        @(negedge clk);
        addr  = a;
        io_en = 1'b1;
        @(negedge clk);
        io_en = 1'b0;
        addr  = 32'd0;
        d     = dout;
    endtask

    task automatic write_reg(input logic [31:0] a, input logic [31:0] d);
        @(negedge clk);
        addr  = a;
        din   = d;
        io_en = 1'b1;
        @(negedge clk);
        io_en = 1'b0;
        addr  = 32'd0;
        din   = 32'd0;
    endtask

    task automatic wait_status(input int bit_pos, input logic level);
        logic [31:0] status;
        read_reg(addr_uart_ctrl, status);
        while (status[bit_pos] !== level) begin
            read_reg(addr_uart_ctrl, status);
        end
    endtask

    task automatic send_frame(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            serial_in = frame[i];
            repeat (clks_per_bit - 1) @(negedge clk);
        end
    endtask

    initial begin : serial_monitor
        logic [7:0] rx_byte;
        forever begin
            @(negedge serial_out);
            repeat (clks_per_bit / 2) @(negedge clk); // move to the centre of the start bit
            check_value("serial_out start bit", 32'd0, {31'd0, serial_out});
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                rx_byte[i] = serial_out;
            end
            repeat (clks_per_bit) @(negedge clk);
            check_value("serial_out stop bit", 32'd1, {31'd0, serial_out});
            tx_seen.push_back(rx_byte);
        end
    end

    initial begin : watchdog
        repeat (watchdog_clks) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", watchdog_clks);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_sequence
        logic [31:0] rd;
        logic [31:0] rnd;
        logic [7:0]  b;
        logic [7:0]  frames[3];
        int          n;
        int          n_inst;
        int          n_br;
        int          n_suc;
        rng       = 32'd39;
        rst       = 1'b1;
        addr      = 32'd0;
        din       = 32'd0;
        io_en     = 1'b0;
        inst_ret  = 1'b0;
        br_inst   = 1'b0;
        br_suc    = 1'b0;
        serial_in = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value("serial_out", 32'd1, {31'd0, serial_out});
        check_value("dout", 32'd0, dout);
        read_reg(addr_uart_ctrl, rd);
        check_value("uart_ctrl", 32'd1, rd);

        // the upper din bits carry random junk that must be ignored
        for (int i = 0; i < 4; i++) begin
            rnd = next_rand();
            b   = rnd[7:0];
            wait_status(0, 1'b1);
            write_reg(addr_uart_tdata, rnd);
            tx_sent.push_back(b);
        end
        while (tx_seen.size() < 4) begin
            @(negedge clk);
        end
        for (int i = 0; i < 4; i++) begin
            check_value("serial_out byte", {24'd0, tx_sent[i]}, {24'd0, tx_seen[i]});
        end

        for (int i = 0; i < 3; i++) begin
            rnd = next_rand();
            b   = rnd[7:0];
            send_frame(b);
            wait_status(1, 1'b1);
            read_reg(addr_uart_rdata, rd);
            check_value("uart_rdata", {24'd0, b}, rd);
            read_reg(addr_uart_ctrl, rd);
            check_value("can_read", 32'd0, {31'd0, rd[1]});
        end

        // the first frame is buffered and the second waits in the receiver while the third is lost
        for (int i = 0; i < 3; i++) begin
            rnd       = next_rand();
            frames[i] = rnd[7:0];
            send_frame(frames[i]);
            repeat (4) @(negedge clk);
        end
        read_reg(addr_uart_rdata, rd);
        check_value("uart_rdata", {24'd0, frames[0]}, rd);
        read_reg(addr_uart_ctrl, rd);
        check_value("can_read", 32'd1, {31'd0, rd[1]});
        read_reg(addr_uart_rdata, rd);
        check_value("uart_rdata", {24'd0, frames[1]}, rd);
        read_reg(addr_uart_ctrl, rd);
        check_value("can_read", 32'd0, {31'd0, rd[1]});
        repeat (frame_clks) @(negedge clk);
        read_reg(addr_uart_ctrl, rd);
        check_value("can_read", 32'd0, {31'd0, rd[1]});
        rnd = next_rand();
        b   = rnd[7:0];
        send_frame(b);
        wait_status(1, 1'b1);
        read_reg(addr_uart_rdata, rd);
        check_value("uart_rdata", {24'd0, b}, rd);

        // the read strobe lands n + 2 edges after the clear
        write_reg(addr_rst_cnt, 32'd0);
        rnd = next_rand();
        n   = int'(rnd % 32'd20);
        repeat (n) @(negedge clk);
        read_reg(addr_cycle_cnt, rd);
        check_value("cycle_cnt", 32'(n + 1), rd);

        write_reg(addr_rst_cnt, 32'd0);
        n_inst = 0;
        n_br   = 0;
        n_suc  = 0;
        for (int i = 0; i < 40; i++) begin
            rnd = next_rand();
            @(negedge clk);
            inst_ret = rnd[0];
            br_inst  = rnd[1];
            br_suc   = rnd[2];
            if (rnd[0]) n_inst++;
            if (rnd[1]) n_br++;
            if (rnd[2]) n_suc++;
        end
        @(negedge clk);
        inst_ret = 1'b0;
        br_inst  = 1'b0;
        br_suc   = 1'b0;
        read_reg(addr_inst_cnt, rd);
        check_value("inst_cnt", 32'(n_inst), rd);
        read_reg(addr_br_inst_cnt, rd);
        check_value("br_inst_cnt", 32'(n_br), rd);
        read_reg(addr_br_suc_cnt, rd);
        check_value("br_suc_cnt", 32'(n_suc), rd);

        read_reg(32'h8000_000C, rd);
        check_value("dout unmapped", 32'd0, rd);
        read_reg(32'h0000_0000, rd);
        check_value("dout unmapped", 32'd0, rd);

        // no frame may appear on serial_out beyond the four that were written
        check_value("serial_out frame count", 32'd4, 32'(tx_seen.size()));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verilog/io_pkg.sv ====
package io_pkg;

    // serial timing
    localparam int clock_freq   = 125_000_000;
    localparam int baud_rate    = 115_200;
    localparam int clks_per_bit = clock_freq / baud_rate;

    localparam int baud_cnt_w = $clog2(clks_per_bit);

    // last count of a full bit period and of half a bit period
    localparam logic [baud_cnt_w-1:0] bit_last  = baud_cnt_w'(clks_per_bit - 1);
    localparam logic [baud_cnt_w-1:0] half_last = baud_cnt_w'(clks_per_bit / 2 - 1);

    // receiver states
    localparam logic [1:0] rx_idle  = 2'd0;
    localparam logic [1:0] rx_start = 2'd1;
    localparam logic [1:0] rx_data  = 2'd2;
    localparam logic [1:0] rx_stop  = 2'd3;

    // memory-mapped I/O addresses
    localparam logic [31:0] addr_uart_ctrl   = 32'h8000_0000; // bit 0 tx_ready, bit 1 can_read
    localparam logic [31:0] addr_uart_rdata  = 32'h8000_0004;
    localparam logic [31:0] addr_uart_tdata  = 32'h8000_0008;
    localparam logic [31:0] addr_cycle_cnt   = 32'h8000_0010;
    localparam logic [31:0] addr_inst_cnt    = 32'h8000_0014;
    localparam logic [31:0] addr_rst_cnt     = 32'h8000_0018; // write clears every counter
    localparam logic [31:0] addr_br_inst_cnt = 32'h8000_001C;
    localparam logic [31:0] addr_br_suc_cnt  = 32'h8000_0020;

endpackage

// ==== verilog/io_regs.sv ====
`timescale 1ns/1ps

module io_regs import io_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addr,
    input  logic [31:0] din,
    input  logic        io_en,
    input  logic        inst_ret,
    input  logic        br_inst,
    input  logic        br_suc,
    uart_if.regs        uart,
    output logic [31:0] dout
);

    logic [7:0]  rx_buf;
    logic        can_read;
    logic [31:0] cycle_cnt;
    logic [31:0] inst_cnt;
    logic [31:0] br_inst_cnt;
    logic [31:0] br_suc_cnt;

    logic [31:0] next_dout;
    logic [7:0]  next_tx_data;
    logic        next_tx_valid;
    logic        next_rx_ready;
    logic [7:0]  next_rx_buf;
    logic        next_can_read;
    logic [31:0] next_cycle_cnt;
    logic [31:0] next_inst_cnt;
    logic [31:0] next_br_inst_cnt;
    logic [31:0] next_br_suc_cnt;

    always_comb begin
        next_dout        = 32'd0;
        next_tx_data     = uart.tx_data;
        next_tx_valid    = uart.tx_valid;
        next_rx_ready    = uart.rx_ready;
        next_rx_buf      = rx_buf;
        next_can_read    = can_read;
        next_cycle_cnt   = cycle_cnt + 32'd1;
        next_inst_cnt    = inst_ret ? inst_cnt + 32'd1 : inst_cnt;
        next_br_inst_cnt = br_inst ? br_inst_cnt + 32'd1 : br_inst_cnt;
        next_br_suc_cnt  = br_suc ? br_suc_cnt + 32'd1 : br_suc_cnt;

        if (uart.tx_valid && uart.tx_ready) begin
            next_tx_valid = 1'b0;
        end

        if (io_en) begin
            case (addr)
                addr_uart_ctrl:   next_dout = {30'd0, can_read, uart.tx_ready};
                addr_uart_rdata: begin
                    next_dout     = {24'd0, rx_buf};
                    next_can_read = 1'b0;
                    next_rx_ready = 1'b1;
                end
                addr_uart_tdata: begin
                    next_tx_data  = din[7:0]; // overwrites a byte not yet taken
                    next_tx_valid = 1'b1;
                end
                addr_cycle_cnt:   next_dout = cycle_cnt;
                addr_inst_cnt:    next_dout = inst_cnt;
                addr_rst_cnt: begin
                    next_cycle_cnt   = 32'd0;
                    next_inst_cnt    = 32'd0;
                    next_br_inst_cnt = 32'd0;
                    next_br_suc_cnt  = 32'd0;
                end
                addr_br_inst_cnt: next_dout = br_inst_cnt;
                addr_br_suc_cnt:  next_dout = br_suc_cnt;
                default:          next_dout = 32'd0;
            endcase
        end

        // capture looks at the buffer state before this edge's read
        if (uart.rx_valid && !can_read) begin
            next_rx_buf   = uart.rx_data;
            next_can_read = 1'b1;
            next_rx_ready = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout          <= 32'd0;
            uart.tx_valid <= 1'b0;
            uart.rx_ready <= 1'b1;
            can_read      <= 1'b0;
            cycle_cnt     <= 32'd0;
            inst_cnt      <= 32'd0;
            br_inst_cnt   <= 32'd0;
            br_suc_cnt    <= 32'd0;
        end else begin
            dout          <= next_dout;
            uart.tx_valid <= next_tx_valid;
            uart.rx_ready <= next_rx_ready;
            can_read      <= next_can_read;
            cycle_cnt     <= next_cycle_cnt;
            inst_cnt      <= next_inst_cnt;
            br_inst_cnt   <= next_br_inst_cnt;
            br_suc_cnt    <= next_br_suc_cnt;
        end
    end

    always_ff @(posedge clk) begin
        uart.tx_data <= next_tx_data;
        rx_buf       <= next_rx_buf;
    end

endmodule

// ==== verilog/io_top.sv ====
`timescale 1ns/1ps

module io_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addr,
    input  logic [31:0] din,
    input  logic        io_en,
    input  logic        inst_ret,
    input  logic        br_inst,
    input  logic        br_suc,
    input  logic        serial_in,
    output logic        serial_out,
    output logic [31:0] dout
);

    // byte streams between the register block and the serial engines
    uart_if uart_i ();

    io_regs io_regs_i (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .din      (din),
        .io_en    (io_en),
        .inst_ret (inst_ret),
        .br_inst  (br_inst),
        .br_suc   (br_suc),
        .uart     (uart_i.regs),
        .dout     (dout)
    );

    uart_tx uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .uart       (uart_i.tx),
        .serial_out (serial_out)
    );

    uart_rx uart_rx_i (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .uart      (uart_i.rx)
    );

endmodule

// ==== verilog/uart_if.sv ====
`timescale 1ns/1ps

interface uart_if;

    // transmit stream, register block to serializer
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;

    // receive stream, deserializer to register block
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;

    modport regs (
        output tx_data,
        output tx_valid,
        input  tx_ready,
        input  rx_data,
        input  rx_valid,
        output rx_ready
    );

    modport tx (
        input  tx_data,
        input  tx_valid,
        output tx_ready
    );

    modport rx (
        output rx_data,
        output rx_valid,
        input  rx_ready
    );

endinterface

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import io_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic serial_in,
    uart_if.rx   uart
);

    logic                  rx_meta;
    logic                  rx_s;
    logic                  rx_prev;
    logic [1:0]            state;
    logic [baud_cnt_w-1:0] clk_cnt;
    logic [2:0]            bit_idx;
    logic [7:0]            data_sr;

    // two-stage synchronizer plus one stage for edge detection
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= serial_in;
            rx_s    <= rx_meta;
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= rx_idle;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            uart.rx_valid <= 1'b0;
        end else begin
            if (uart.rx_valid && uart.rx_ready) begin
                uart.rx_valid <= 1'b0;
            end

            case (state)
                rx_idle: begin
                    if (rx_prev && !rx_s) begin
                        state   <= rx_start;
                        clk_cnt <= '0;
                    end
                end
                rx_start: begin
                    if (clk_cnt == half_last) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? rx_idle : rx_data; // a glitch shorter than half a bit is ignored
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        state   <= rx_idle;

                        // the byte is lost if the previous one is still waiting
                        if (rx_s && !uart.rx_valid) begin
                            uart.rx_valid <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == rx_data && clk_cnt == bit_last) begin
            data_sr <= {rx_s, data_sr[7:1]};
        end
        if (state == rx_stop && clk_cnt == bit_last && rx_s && !uart.rx_valid) begin
            uart.rx_data <= data_sr;
        end
    end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import io_pkg::*; (
    input  logic clk,
    input  logic rst,
    uart_if.tx   uart,
    output logic serial_out
);

    logic [baud_cnt_w-1:0] clk_cnt;
    logic [3:0]            bit_idx;
    logic [9:0]            shift_q;
    logic                  busy;

    assign uart.tx_ready = !busy;

    // the shifter fills with ones behind the frame, so the line idles high
    assign serial_out = shift_q[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift_q <= '1;
        end else if (!busy) begin
            if (uart.tx_valid) begin // ready is high while idle, so this is the handshake
                shift_q <= {1'b1, uart.tx_data, 1'b0};
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (clk_cnt == bit_last) begin
            clk_cnt <= '0;
            shift_q <= {1'b1, shift_q[9:1]};

            // bit 9 is the stop bit
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule
